// File: sim.f
common/stlb_pkg.sv
common/ecc_pkg.sv
common/stlb_ram_if.sv
common/stlb_cfg_if.sv
ecc/secded_decode.sv
stlb/stlb_data_ecc_ram.sv
stlb/stlb_lookup.sv
src/stlb_csr.sv
src/stlb_top.sv
sim/tb_stlb.sv

// File: Makefile
# Verilator build and run for the STLB testbench.

VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal -j 0
TOP       = tb_stlb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
LOG       = sim.log
PASS_MSG  = SIMULATION PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The log decides the result, so a crash or a failed check both fail the target.
run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Run passed."; \
	else \
		echo "Run failed, see $(LOG)."; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/tb_stlb.sv
// Self-checking STLB testbench; the buffer is flushed before the first lookup, RAM starts undefined.
`timescale 1ns/1ps
`default_nettype none

module tb_stlb;
	import stlb_pkg::*;

	localparam int CLK_PERIOD = 40;
	localparam int ENTRIES = 2**STLB_IDX_W;
	localparam int ROW_CYCLES = 64; // Watchdog budget per table row.
	localparam logic [31:0] LFSR_SEED = 32'h6309;
	localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

	typedef enum logic [2:0] {
		OP_CSR_WR,
		OP_CSR_CHK,
		OP_FILL,
		OP_LOOKUP,
		OP_SWEEP // Lookup of every index under one tag, all expected to miss.
	} op_kind_t;

	typedef struct packed {
		op_kind_t              kind;
		logic [CSR_ADDR_W-1:0] addr;
		logic [CSR_DATA_W-1:0] data; // Write data, or the expected read value.
		stlb_vpn_t             vpn;
		stlb_ppn_t             ppn;
		stlb_perm_t            perm;
		logic                  hit;
		logic                  err;
	} op_t;

	logic                  clk;
	logic                  rst;
	logic                  req_valid;
	logic                  req_ready;
	stlb_vpn_t             req_vpn;
	logic                  rsp_valid;
	logic                  rsp_ready;
	logic                  rsp_hit;
	stlb_ppn_t             rsp_ppn;
	stlb_perm_t            rsp_perm;
	logic                  rsp_err;
	logic                  fill_valid;
	logic                  fill_ready;
	stlb_vpn_t             fill_vpn;
	stlb_ppn_t             fill_ppn;
	stlb_perm_t            fill_perm;
	logic                  csr_wr;
	logic [CSR_ADDR_W-1:0] csr_addr;
	logic [CSR_DATA_W-1:0] csr_wdata;
	logic [CSR_DATA_W-1:0] csr_rdata;

	op_t         ops[$];
	int          table_len = 0;
	int          transfers = 0;
	int          expected_rsps = 0;
	logic [31:0] lfsr_state;

	stlb_top i_dut (.*);

	always #(CLK_PERIOD / 2) clk = ~clk;

	// Every response handshake is counted here, independent of the lookup task.
	always @(negedge clk) begin
		if (!rst && rsp_valid && rsp_ready) begin
			transfers++;
		end
	end

	initial begin
		wait (table_len > 0);
		#(table_len * ROW_CYCLES * CLK_PERIOD);
		$display("Timeout: the test table did not complete within the time allowed.");
		$display("SIMULATION FAILED");
		$fatal(1, "watchdog expired");
	end

	// ====================
	// Helpers
	// ====================
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
	endfunction

	task automatic report_error(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("SIMULATION FAILED");
		$fatal(1, "first error reached");
	endtask

	task automatic check_rsp(
		input logic got_hit, input stlb_ppn_t got_ppn, input stlb_perm_t got_perm,
		input logic got_err, input logic exp_hit, input stlb_ppn_t exp_ppn,
		input stlb_perm_t exp_perm, input logic exp_err, input string what
	);
		if (got_hit !== exp_hit || got_err !== exp_err
				|| (exp_hit && (got_ppn !== exp_ppn || got_perm !== exp_perm))) begin
			report_error($sformatf("%s: got hit %b ppn %h perm %b err %b, expected %b %h %b %b",
				what, got_hit, got_ppn, got_perm, got_err, exp_hit, exp_ppn, exp_perm, exp_err));
		end
	endtask

	task automatic check_cnt(input stlb_cnt_t got, input stlb_cnt_t exp, input string what);
		if (got !== exp) begin
			report_error($sformatf("%s: got %0d, expected %0d", what, got, exp));
		end
	endtask

	task automatic check_csr(input logic [CSR_DATA_W-1:0] got, input logic [CSR_DATA_W-1:0] exp,
		input string what);
		if (got !== exp) begin
			report_error($sformatf("%s: got %h, expected %h", what, got, exp));
		end
	endtask

	function automatic void add_row(input op_kind_t kind, input logic [CSR_ADDR_W-1:0] addr,
		input logic [CSR_DATA_W-1:0] data, input stlb_vpn_t vpn, input stlb_ppn_t ppn,
		input stlb_perm_t perm, input logic hit, input logic err);
		op_t row;
		row.kind = kind;
		row.addr = addr;
		row.data = data;
		row.vpn  = vpn;
		row.ppn  = ppn;
		row.perm = perm;
		row.hit  = hit;
		row.err  = err;
		ops.push_back(row);
	endfunction

	// ====================
	// Bus tasks
	// ====================
	// A flush write waits out the busy window: one request cycle, then one write per entry.
	task automatic csr_write(input logic [CSR_ADDR_W-1:0] addr, input logic [CSR_DATA_W-1:0] data);
		int busy;
		busy = 0;
		@(posedge clk);
		csr_wr    <= 1'b1;
		csr_addr  <= addr;
		csr_wdata <= data;
		@(posedge clk);
		csr_wr <= 1'b0;
		@(negedge clk);
		while (!fill_ready) begin
			busy++;
			if (addr == CSR_CTRL && !csr_rdata[CTRL_FLUSH_BIT]) begin
				report_error("flush bit reads back 0 while the engine is still flushing");
			end
			if (req_ready) begin
				report_error("req_ready is high during a flush");
			end
			@(negedge clk);
		end
		if (addr == CSR_CTRL && data[CTRL_FLUSH_BIT] && busy != ENTRIES + 1) begin
			report_error($sformatf("flush kept the engine busy for %0d cycles", busy));
		end
	endtask

	task automatic csr_check(input logic [CSR_ADDR_W-1:0] addr, input logic [CSR_DATA_W-1:0] exp);
		@(posedge clk);
		csr_addr <= addr;
		@(negedge clk);
		if (addr == CSR_CE_CNT || addr == CSR_UE_CNT) begin
			check_cnt(csr_rdata[STLB_CNT_W-1:0], exp[STLB_CNT_W-1:0],
				$sformatf("counter at register %0d", addr));
		end else begin
			check_csr(csr_rdata, exp, $sformatf("register %0d", addr));
		end
	endtask

	task automatic refill(input stlb_vpn_t vpn, input stlb_ppn_t ppn, input stlb_perm_t perm);
		@(posedge clk);
		fill_valid <= 1'b1;
		fill_vpn   <= vpn;
		fill_ppn   <= ppn;
		fill_perm  <= perm;
		@(negedge clk);
		while (!fill_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		fill_valid <= 1'b0;
	endtask

	// rsp_ready follows the LFSR, so a response may sit through several stalls.
	task automatic lookup(input stlb_vpn_t vpn, input logic exp_hit, input stlb_ppn_t exp_ppn,
		input stlb_perm_t exp_perm, input logic exp_err);
		logic       seen;
		logic       done;
		int         cycles;
		logic       held_hit;
		stlb_ppn_t  held_ppn;
		stlb_perm_t held_perm;
		logic       held_err;
		seen   = 1'b0;
		done   = 1'b0;
		cycles = 0;
		@(posedge clk);
		req_valid <= 1'b1;
		req_vpn   <= vpn;
		@(negedge clk);
		while (!req_ready) begin
			@(negedge clk);
		end
		@(posedge clk);
		req_valid <= 1'b0;
		while (!done) begin
			lfsr_state = lfsr_step(lfsr_state);
			rsp_ready <= lfsr_state[0];
			@(negedge clk);
			cycles++;
			if (req_ready) begin
				report_error("req_ready rose while a lookup was still in flight");
			end
			if (rsp_valid) begin
				if (!seen) begin
					if (cycles != 2) begin
						report_error($sformatf("response came %0d edges after acceptance", cycles));
					end
					check_rsp(rsp_hit, rsp_ppn, rsp_perm, rsp_err, exp_hit, exp_ppn, exp_perm,
						exp_err, $sformatf("lookup of %h", vpn));
					held_hit  = rsp_hit;
					held_ppn  = rsp_ppn;
					held_perm = rsp_perm;
					held_err  = rsp_err;
					seen      = 1'b1;
				end else begin
					check_rsp(rsp_hit, rsp_ppn, rsp_perm, rsp_err, held_hit, held_ppn, held_perm,
						held_err, $sformatf("stalled response of %h", vpn));
				end
				done = rsp_ready;
			end
			@(posedge clk);
		end
		expected_rsps++;
	endtask

	// ====================
	// Test table
	// ====================
	task automatic build_table();
		// Reset state, enable with flush, then every index must miss.
		add_row(OP_CSR_CHK, CSR_CE_CNT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_UE_CNT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_CTRL, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_WR, CSR_CTRL, 32'h3, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_CTRL, 32'h1, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_SWEEP, CSR_CTRL, 32'h0, 16'h1230, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_CE_CNT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_UE_CNT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		// Refill and hit, tag mismatch, overwrite.
		add_row(OP_FILL, CSR_CTRL, 32'h0, 16'h1a21, 16'hbeef, 3'b101, 1'b0, 1'b0);
		add_row(OP_FILL, CSR_CTRL, 32'h0, 16'h0042, 16'h1234, 3'b011, 1'b0, 1'b0);
		add_row(OP_FILL, CSR_CTRL, 32'h0, 16'hfff7, 16'h8001, 3'b110, 1'b0, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'h1a21, 16'hbeef, 3'b101, 1'b1, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'h0042, 16'h1234, 3'b011, 1'b1, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'hfff7, 16'h8001, 3'b110, 1'b1, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'h5a21, '0, '0, 1'b0, 1'b0);
		add_row(OP_FILL, CSR_CTRL, 32'h0, 16'h0042, 16'h4321, 3'b100, 1'b0, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'h0042, 16'h4321, 3'b100, 1'b1, 1'b0);
		add_row(OP_FILL, CSR_CTRL, 32'h0, 16'h7702, 16'h0f0f, 3'b001, 1'b0, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'h0042, '0, '0, 1'b0, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'h7702, 16'h0f0f, 3'b001, 1'b1, 1'b0);
		// One flipped bit is corrected and counted.
		add_row(OP_CSR_WR, CSR_INJECT, 32'h0000_0100, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_INJECT, 32'h0000_0100, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_FILL, CSR_CTRL, 32'h0, 16'h3c05, 16'h5555, 3'b111, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_INJECT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'h3c05, 16'h5555, 3'b111, 1'b1, 1'b0);
		add_row(OP_CSR_CHK, CSR_CE_CNT, 32'h1, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_UE_CNT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		// Two flipped bits give an error response.
		add_row(OP_CSR_WR, CSR_INJECT, 32'h0001_0010, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_FILL, CSR_CTRL, 32'h0, 16'h9e0b, 16'haaaa, 3'b010, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_INJECT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'h9e0b, '0, '0, 1'b0, 1'b1);
		add_row(OP_CSR_CHK, CSR_UE_CNT, 32'h1, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_CE_CNT, 32'h1, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_WR, CSR_UE_CNT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_UE_CNT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_WR, CSR_CE_CNT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_CE_CNT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		// Disable, then flush and enable again.
		add_row(OP_CSR_WR, CSR_CTRL, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'h1a21, '0, '0, 1'b0, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'hfff7, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_WR, CSR_CTRL, 32'h2, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_WR, CSR_CTRL, 32'h1, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'h1a21, '0, '0, 1'b0, 1'b0);
		add_row(OP_LOOKUP, CSR_CTRL, 32'h0, 16'h7702, '0, '0, 1'b0, 1'b0);
		add_row(OP_SWEEP, CSR_CTRL, 32'h0, 16'h3c00, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_CE_CNT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
		add_row(OP_CSR_CHK, CSR_UE_CNT, 32'h0, '0, '0, '0, 1'b0, 1'b0);
	endtask

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		req_valid  = 1'b0;
		req_vpn    = '0;
		rsp_ready  = 1'b1;
		fill_valid = 1'b0;
		fill_vpn   = '0;
		fill_ppn   = '0;
		fill_perm  = '0;
		csr_wr     = 1'b0;
		csr_addr   = '0;
		csr_wdata  = '0;
		lfsr_state = LFSR_SEED;
		build_table();
		table_len = ops.size();
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		if (!req_ready || !fill_ready || rsp_valid) begin
			report_error("handshake outputs are wrong after reset");
		end
		foreach (ops[i]) begin
			case (ops[i].kind)
				OP_CSR_WR:  csr_write(ops[i].addr, ops[i].data);
				OP_CSR_CHK: csr_check(ops[i].addr, ops[i].data);
				OP_FILL:    refill(ops[i].vpn, ops[i].ppn, ops[i].perm);
				OP_LOOKUP:  lookup(ops[i].vpn, ops[i].hit, ops[i].ppn, ops[i].perm, ops[i].err);
				OP_SWEEP: begin
					for (int j = 0; j < ENTRIES; j++) begin
						lookup({ops[i].vpn[STLB_VPN_W-1:STLB_IDX_W], STLB_IDX_W'(j)},
							1'b0, '0, '0, 1'b0);
					end
				end
				default: report_error("unknown operation in the test table");
			endcase
		end
		if (transfers != expected_rsps) begin
			report_error($sformatf("%0d responses transferred, expected %0d",
				transfers, expected_rsps));
		end else begin
			$display("SIMULATION PASSED");
			$finish;
		end
	end

endmodule

`default_nettype wire

// File: src/stlb_top.sv
// STLB top; the buffer must be flushed once after reset before lookups can be trusted.
`timescale 1ns/1ps
`default_nettype none

module stlb_top (
	input wire                              clk,
	input wire                              rst,
	// Lookup request and response.
	input wire                              req_valid,
	output logic                            req_ready,
	input wire stlb_pkg::stlb_vpn_t          req_vpn,
	output logic                            rsp_valid,
	input wire                              rsp_ready,
	output logic                            rsp_hit,
	output stlb_pkg::stlb_ppn_t              rsp_ppn,
	output stlb_pkg::stlb_perm_t             rsp_perm,
	output logic                            rsp_err,
	// Refill.
	input wire                              fill_valid,
	output logic                            fill_ready,
	input wire stlb_pkg::stlb_vpn_t          fill_vpn,
	input wire stlb_pkg::stlb_ppn_t          fill_ppn,
	input wire stlb_pkg::stlb_perm_t         fill_perm,
	// Registers.
	input wire                              csr_wr,
	input wire [stlb_pkg::CSR_ADDR_W-1:0]    csr_addr,
	input wire [stlb_pkg::CSR_DATA_W-1:0]    csr_wdata,
	output logic [stlb_pkg::CSR_DATA_W-1:0]  csr_rdata
);
	import stlb_pkg::*;
	import ecc_pkg::*;

	stlb_ram_if ram_if ();
	stlb_cfg_if cfg_if ();

	stlb_csr i_csr (
		.clk       (clk),
		.rst       (rst),
		.csr_wr    (csr_wr),
		.csr_addr  (csr_addr),
		.csr_wdata (csr_wdata),
		.csr_rdata (csr_rdata),
		.cfg       (cfg_if.csr)
	);

	stlb_lookup i_lookup (
		.clk        (clk),
		.rst        (rst),
		.req_valid  (req_valid),
		.req_ready  (req_ready),
		.req_vpn    (req_vpn),
		.rsp_valid  (rsp_valid),
		.rsp_ready  (rsp_ready),
		.rsp_hit    (rsp_hit),
		.rsp_ppn    (rsp_ppn),
		.rsp_perm   (rsp_perm),
		.rsp_err    (rsp_err),
		.fill_valid (fill_valid),
		.fill_ready (fill_ready),
		.fill_vpn   (fill_vpn),
		.fill_ppn   (fill_ppn),
		.fill_perm  (fill_perm),
		.ram        (ram_if.engine),
		.cfg        (cfg_if.engine)
	);

	stlb_data_ecc_ram #(
		.addr_w (STLB_IDX_W),
		.data_w (ECC_CODE_W)
	) i_ram (
		.clk (clk),
		.ram (ram_if.mem)
	);

endmodule

`default_nettype wire

// File: src/stlb_csr.sv
// Four registers, write-only side effects; counters saturate and any write to one clears it.
`timescale 1ns/1ps
`default_nettype none

module stlb_csr (
	input wire                              clk,
	input wire                              rst,
	input wire                              csr_wr,
	input wire [stlb_pkg::CSR_ADDR_W-1:0]    csr_addr,
	input wire [stlb_pkg::CSR_DATA_W-1:0]    csr_wdata,
	output logic [stlb_pkg::CSR_DATA_W-1:0]  csr_rdata,
	stlb_cfg_if.csr                         cfg
);
	import stlb_pkg::*;

	logic                  enable_q;
	logic                  flush_req_q;
	logic [CSR_DATA_W-1:0] inject_q;
	stlb_cnt_t             ce_cnt_q;
	stlb_cnt_t             ue_cnt_q;

	assign cfg.enable      = enable_q;
	assign cfg.flush_req   = flush_req_q;
	assign cfg.inject_mask = inject_q;

	always_ff @(posedge clk) begin
		if (rst) begin
			enable_q    <= 1'b0;
			flush_req_q <= 1'b0;
			inject_q    <= '0;
			ce_cnt_q    <= '0;
			ue_cnt_q    <= '0;
		end else begin
			flush_req_q <= csr_wr && (csr_addr == CSR_CTRL) && csr_wdata[CTRL_FLUSH_BIT];
			if (csr_wr && (csr_addr == CSR_CTRL)) begin
				enable_q <= csr_wdata[CTRL_ENABLE_BIT];
			end
			// A new mask written in the same cycle as a refill survives.
			if (csr_wr && (csr_addr == CSR_INJECT)) begin
				inject_q <= csr_wdata;
			end else if (cfg.inject_done) begin
				inject_q <= '0;
			end
			if (csr_wr && (csr_addr == CSR_CE_CNT)) begin
				ce_cnt_q <= '0;
			end else if (cfg.ce_event && (ce_cnt_q != '1)) begin
				ce_cnt_q <= ce_cnt_q + 1'b1;
			end
			if (csr_wr && (csr_addr == CSR_UE_CNT)) begin
				ue_cnt_q <= '0;
			end else if (cfg.ue_event && (ue_cnt_q != '1)) begin
				ue_cnt_q <= ue_cnt_q + 1'b1;
			end
		end
	end

	always_comb begin
		csr_rdata = '0;
		case (csr_addr)
			CSR_CTRL: begin
				csr_rdata[CTRL_ENABLE_BIT] = enable_q;
				csr_rdata[CTRL_FLUSH_BIT]  = cfg.flush_busy; // Reads back busy, not the request.
			end
			CSR_INJECT: csr_rdata = inject_q;
			CSR_CE_CNT: csr_rdata = {{(CSR_DATA_W - STLB_CNT_W){1'b0}}, ce_cnt_q};
			CSR_UE_CNT: csr_rdata = {{(CSR_DATA_W - STLB_CNT_W){1'b0}}, ue_cnt_q};
			default:    csr_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: stlb/stlb_lookup.sv
// One lookup in flight; a refill beats a same-cycle request and a flush blocks both for 16 cycles.
`timescale 1ns/1ps
`default_nettype none

module stlb_lookup (
	input wire                      clk,
	input wire                      rst,
	input wire                      req_valid,
	output logic                    req_ready,
	input wire stlb_pkg::stlb_vpn_t  req_vpn,
	output logic                    rsp_valid,
	input wire                      rsp_ready,
	output logic                    rsp_hit,
	output stlb_pkg::stlb_ppn_t      rsp_ppn,
	output stlb_pkg::stlb_perm_t     rsp_perm,
	output logic                    rsp_err,
	input wire                      fill_valid,
	output logic                    fill_ready,
	input wire stlb_pkg::stlb_vpn_t  fill_vpn,
	input wire stlb_pkg::stlb_ppn_t  fill_ppn,
	input wire stlb_pkg::stlb_perm_t fill_perm,
	stlb_ram_if.engine              ram,
	stlb_cfg_if.engine              cfg
);
	import stlb_pkg::*;
	import ecc_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_READ,
		ST_RESP,
		ST_FLUSH
	} state_t;

	state_t                state_q;
	stlb_tag_t             tag_q;
	stlb_idx_t             flush_idx_q;
	logic                  flush_pend_q;
	logic                  flush_start;
	logic                  req_fire;
	logic                  fill_fire;
	stlb_entry_t           fill_entry;
	ecc_code_t             fill_code;
	logic [ECC_DATA_W-1:0] dec_data;
	stlb_entry_t           dec_entry;
	logic                  dec_ce;
	logic                  dec_ue;
	logic                  resp_hit;

	// ====================
	// Handshakes
	// ====================
	// A flush request that arrives while a lookup is busy waits in flush_pend_q.
	assign flush_start = (state_q == ST_IDLE) && (cfg.flush_req || flush_pend_q);
	assign fill_ready  = (state_q == ST_IDLE) && !cfg.flush_req && !flush_pend_q;
	assign req_ready   = fill_ready && !fill_valid; // Refill has priority.
	assign fill_fire   = fill_valid && fill_ready;
	assign req_fire    = req_valid && req_ready;
	assign rsp_valid   = (state_q == ST_RESP);

	assign cfg.flush_busy  = (state_q == ST_FLUSH) || flush_pend_q || cfg.flush_req;
	assign cfg.inject_done = fill_fire && (cfg.inject_mask != '0);
	assign cfg.ce_event    = (state_q == ST_READ) && dec_ce; // Once per response.
	assign cfg.ue_event    = (state_q == ST_READ) && dec_ue;

	// ====================
	// RAM port
	// ====================
	assign fill_entry = '{
		valid: 1'b1,
		tag:   fill_vpn[STLB_VPN_W-1 -: STLB_TAG_W],
		ppn:   fill_ppn,
		perm:  fill_perm
	};
	// Injected errors land on the data bits only.
	assign fill_code = secded_encode(fill_entry) ^ {{ECC_CHECK_W{1'b0}}, cfg.inject_mask};

	always_comb begin
		ram.cs    = 1'b0;
		ram.we    = 1'b0;
		ram.addr  = req_vpn[STLB_IDX_W-1:0];
		ram.wdata = fill_code;
		if (state_q == ST_FLUSH) begin
			ram.cs    = 1'b1;
			ram.we    = 1'b1;
			ram.addr  = flush_idx_q;
			ram.wdata = secded_encode('0); // An all-zero entry is invalid.
		end else if (fill_fire) begin
			ram.cs   = 1'b1;
			ram.we   = 1'b1;
			ram.addr = fill_vpn[STLB_IDX_W-1:0];
		end else if (req_fire) begin
			ram.cs = 1'b1;
		end
	end

	secded_decode i_decode (
		.code (ram.rdata),
		.data (dec_data),
		.ce   (dec_ce),
		.ue   (dec_ue)
	);

	assign dec_entry = stlb_entry_t'(dec_data);
	assign resp_hit  = cfg.enable && dec_entry.valid && (dec_entry.tag == tag_q) && !dec_ue;

	// ====================
	// FSM
	// ====================
	always_ff @(posedge clk) begin
		if (rst) begin
			state_q      <= ST_IDLE;
			flush_idx_q  <= '0;
			flush_pend_q <= 1'b0;
		end else begin
			flush_pend_q <= (flush_pend_q || cfg.flush_req) && !flush_start;
			case (state_q)
				ST_IDLE: begin
					if (flush_start) begin
						state_q     <= ST_FLUSH;
						flush_idx_q <= '0;
					end else if (req_fire) begin
						state_q <= ST_READ;
					end
				end
				ST_READ: state_q <= ST_RESP; // RAM data is valid now.
				ST_RESP: begin
					if (rsp_ready) begin
						state_q <= ST_IDLE;
					end
				end
				ST_FLUSH: begin
					flush_idx_q <= flush_idx_q + 1'b1;
					if (flush_idx_q == '1) begin
						state_q <= ST_IDLE;
					end
				end
				default: state_q <= ST_IDLE;
			endcase
		end
	end

	// The response registers load once per lookup and hold through back-pressure.
	always_ff @(posedge clk) begin
		if (req_fire) begin
			tag_q <= req_vpn[STLB_VPN_W-1 -: STLB_TAG_W];
		end
		if (state_q == ST_READ) begin
			rsp_hit  <= resp_hit;
			rsp_ppn  <= resp_hit ? dec_entry.ppn : '0;
			rsp_perm <= resp_hit ? dec_entry.perm : '0;
			rsp_err  <= dec_ue;
		end
	end

endmodule

`default_nettype wire

// File: stlb/stlb_data_ecc_ram.sv
// Behavioural single-port RAM; contents are undefined until written, reads have one cycle latency.
`timescale 1ns/1ps
`default_nettype none

module stlb_data_ecc_ram #(
	parameter int addr_w = 4,
	parameter int data_w = 39
) (
	input wire       clk,
	stlb_ram_if.mem  ram
);

	logic [data_w-1:0] words [2**addr_w];

	// Write and read share the one port, so a write cycle leaves rdata alone.
	always_ff @(posedge clk) begin
		if (ram.cs) begin
			if (ram.we) begin
				words[ram.addr] <= ram.wdata;
			end else begin
				ram.rdata <= words[ram.addr]; // Holds until the next read.
			end
		end
	end

endmodule

`default_nettype wire

// File: ecc/secded_decode.sv
// Combinational SECDED check; three or more flipped bits are not reliably detected.
`timescale 1ns/1ps
`default_nettype none

module secded_decode (
	input wire ecc_pkg::ecc_code_t            code,
	output logic [ecc_pkg::ECC_DATA_W-1:0]   data,
	output logic                             ce,
	output logic                             ue
);
	import ecc_pkg::*;

	logic [ECC_DATA_W-1:0] raw;
	logic [ECC_HAM_W-1:0]  chk;
	ecc_syndrome_t         syn;

	assign raw = code[ECC_DATA_W-1:0];
	assign chk = code[ECC_DATA_W +: ECC_HAM_W];
	assign syn = {^code, secded_check(raw) ^ chk};

	// Odd parity means one flipped bit. Even parity with a nonzero syndrome means two.
	assign ce = syn[ECC_CHECK_W-1];
	assign ue = !syn[ECC_CHECK_W-1] && (syn[ECC_HAM_W-1:0] != '0);

	// The syndrome names the Hamming position of the bad bit. A flipped check
	// or parity bit matches no data position and leaves the data alone.
	always_comb begin
		data = raw;
		for (int i = 0; i < ECC_DATA_W; i++) begin
			if (ce && (syn[ECC_HAM_W-1:0] == secded_check(ECC_DATA_W'(1) << i))) begin
				data[i] = ~raw[i];
			end
		end
	end

endmodule

`default_nettype wire

// File: common/stlb_cfg_if.sv
// Control from the register block to the engine; flush_req and all events are one-cycle pulses.
`timescale 1ns/1ps
`default_nettype none

interface stlb_cfg_if;

	logic                          enable;
	logic                          flush_req;
	logic [ecc_pkg::ECC_DATA_W-1:0] inject_mask;
	logic                          flush_busy;
	logic                          inject_done;
	logic                          ce_event;
	logic                          ue_event;

	modport csr (output enable, flush_req, inject_mask,
		input flush_busy, inject_done, ce_event, ue_event);
	modport engine (input enable, flush_req, inject_mask,
		output flush_busy, inject_done, ce_event, ue_event);

endinterface

`default_nettype wire

// File: common/stlb_ram_if.sv
// Single-port data RAM bus; rdata is valid after a read edge and holds until the next read.
`timescale 1ns/1ps
`default_nettype none

interface stlb_ram_if;
	import stlb_pkg::*;
	import ecc_pkg::*;

	logic      cs;
	logic      we;
	stlb_idx_t addr;
	ecc_code_t wdata;
	ecc_code_t rdata;

	modport engine (output cs, we, addr, wdata, input rdata);
	modport mem (input cs, we, addr, wdata, output rdata);

endinterface

`default_nettype wire

// File: common/ecc_pkg.sv
// Extended Hamming SECDED over 32 data bits; data sits in the low bits, then check, then parity.
package ecc_pkg;

	localparam int ECC_DATA_W  = 32;
	localparam int ECC_CHECK_W = 7;
	localparam int ECC_HAM_W   = ECC_CHECK_W - 1; // Hamming bits without the overall parity.
	localparam int ECC_CODE_W  = ECC_DATA_W + ECC_CHECK_W;

	typedef logic [ECC_CODE_W-1:0]  ecc_code_t;
	typedef logic [ECC_CHECK_W-1:0] ecc_syndrome_t; // Overall parity in the top bit.

	// ====================
	// Check bit generation
	// ====================
	// Each data bit owns a Hamming position that is not a power of two,
	// so the check word is the XOR of the positions of all set data bits.
	function automatic logic [ECC_HAM_W-1:0] secded_check(input logic [ECC_DATA_W-1:0] data);
		logic [ECC_HAM_W-1:0] chk;
		logic [ECC_HAM_W-1:0] pos;
		chk = '0;
		pos = ECC_HAM_W'(3);
		for (int i = 0; i < ECC_DATA_W; i++) begin
			if (data[i]) begin
				chk = chk ^ pos;
			end
			pos = pos + 1'b1;
			if ((pos & (pos - 1'b1)) == '0) begin
				pos = pos + 1'b1; // Skip the check bit positions.
			end
		end
		return chk;
	endfunction

	// The overall parity bit makes the XOR of the full codeword zero.
	function automatic ecc_code_t secded_encode(input logic [ECC_DATA_W-1:0] data);
		logic [ECC_HAM_W-1:0] chk;
		chk = secded_check(data);
		return {^{chk, data}, chk, data};
	endfunction

endpackage

// File: common/stlb_pkg.sv
// Entry layout and register map for a 16-entry direct-mapped STLB; index is the low VPN bits.
package stlb_pkg;

	// ====================
	// Translation entry
	// ====================
	localparam int STLB_VPN_W  = 16;
	localparam int STLB_IDX_W  = 4; // Also the data RAM address width.
	localparam int STLB_TAG_W  = 12; // Upper VPN bits above the index.
	localparam int STLB_PPN_W  = 16;
	localparam int STLB_PERM_W = 3;

	typedef logic [STLB_VPN_W-1:0]  stlb_vpn_t;
	typedef logic [STLB_IDX_W-1:0]  stlb_idx_t;
	typedef logic [STLB_TAG_W-1:0]  stlb_tag_t;
	typedef logic [STLB_PPN_W-1:0]  stlb_ppn_t;
	typedef logic [STLB_PERM_W-1:0] stlb_perm_t;

	// Packs into exactly one 32-bit ECC data word.
	typedef struct packed {
		logic       valid;
		stlb_tag_t  tag;
		stlb_ppn_t  ppn;
		stlb_perm_t perm;
	} stlb_entry_t;

	// ====================
	// Register map
	// ====================
	localparam int STLB_CNT_W = 16;
	typedef logic [STLB_CNT_W-1:0] stlb_cnt_t; // Saturates at all ones.

	localparam int CSR_ADDR_W = 2;
	localparam int CSR_DATA_W = 32;

	localparam logic [CSR_ADDR_W-1:0] CSR_CTRL   = 2'd0;
	localparam logic [CSR_ADDR_W-1:0] CSR_INJECT = 2'd1;
	localparam logic [CSR_ADDR_W-1:0] CSR_CE_CNT = 2'd2;
	localparam logic [CSR_ADDR_W-1:0] CSR_UE_CNT = 2'd3;

	// Bit positions inside CSR_CTRL.
	localparam int CTRL_ENABLE_BIT = 0;
	localparam int CTRL_FLUSH_BIT  = 1;

endpackage
